// File: src/nes_bus_pkg.sv
// ##############################
// NES CPU bus types, memory map
// addresses and bus structs
// ##############################
package nes_bus_pkg;

	typedef logic [15:0] addr_t;   // CPU address
	typedef logic [7:0]  data_t;   // One bus byte
	typedef logic [4:0]  pad_t;    // Joypad serial bits D0..D4

	// Memory map
	localparam addr_t ADDR_OAM_DATA = 16'h2004;   // PPU sprite data port
	localparam addr_t ADDR_OAM_DMA  = 16'h4014;   // Sprite DMA page trigger
	localparam addr_t ADDR_JOY1     = 16'h4016;   // Strobe on write, pad 1 on read
	localparam addr_t ADDR_JOY2     = 16'h4017;   // Pad 2 on read
	localparam logic [10:0] APU_PAGE = 11'h200;   // addr[15:5] of $4000..$401F

	// What the CPU puts on the bus each cycle
	typedef struct packed {
		addr_t addr;
		logic  rnw;    // 1 = read
		data_t dout;   // Write data
	} cpu_bus_t;

	// Request to the external memory
	typedef struct packed {
		addr_t addr;
		logic  read;
		logic  write;
		data_t wdata;
	} mem_req_t;

endpackage

// File: src/nes_timing_pkg.sv
// ##############################
// CPU clock divider constant and
// DMA state encodings
// ##############################
package nes_timing_pkg;

	localparam logic [3:0] CPU_DIV = 4'd12;   // Master clocks per CPU cycle, NTSC

	// Bit 0 set means the CPU is held
	typedef enum logic [1:0] {
		SPR_IDLE = 2'b00,
		SPR_WAIT = 2'b01,   // Halted, waiting for a GET to align
		SPR_RUN  = 2'b11    // Read/write pairs in progress
	} spr_state_t;

	typedef enum logic {
		DMC_IDLE = 1'b0,
		DMC_RUN  = 1'b1     // One GET cycle being stolen
	} dmc_state_t;

endpackage

// File: src/nes_clock_gen.sv
// ##############################
// Master clock divider, CPU clock
// enable and GET/PUT parity
// ##############################
module nes_clock_gen
	import nes_timing_pkg::*;
(
	input  logic clk,
	input  logic reset,
	output logic cpu_ce,
	output logic get_ce,
	output logic put_ce,
	output logic put_cycle
);

	logic [3:0] div_cnt;   // Runs 1..CPU_DIV

	assign cpu_ce = (div_cnt == CPU_DIV);

	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt   <= 4'd1;
			put_cycle <= 1'b1;   // Odd after reset
		end else begin
			div_cnt <= cpu_ce ? 4'd1 : div_cnt + 4'd1;
			if (cpu_ce)
				put_cycle <= !put_cycle;   // Parity flips every CPU cycle
		end
	end

	// Enable at the end of a GET or a PUT cycle
	assign get_ce = cpu_ce && !put_cycle;
	assign put_ce = cpu_ce && put_cycle;

endmodule

// File: src/sprite_dma.sv
// ##############################
// Sprite DMA, copies one page to
// the PPU sprite port at $2004
// ##############################
module sprite_dma
	import nes_bus_pkg::*;
	import nes_timing_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_ce,
	input  logic     get_ce,
	input  logic     put_ce,
	input  logic     put_cycle,
	input  logic     dmc_busy,
	input  cpu_bus_t cpu_bus,
	input  data_t    bus_rdata,
	output logic     spr_wait,
	output logic     spr_run,
	output addr_t    spr_addr,
	output data_t    spr_data
);

	spr_state_t state;
	data_t      page;      // Source page from the $4014 write
	logic [8:0] index;     // Bit 8 is the end of page carry
	logic       fetched;   // A byte is latched and waits for its PUT
	logic       trigger;

	assign trigger = !cpu_bus.rnw && (cpu_bus.addr == ADDR_OAM_DMA);

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= SPR_IDLE;
			index   <= '0;
			fetched <= 1'b0;
		end else if (cpu_ce) begin
			case (state)
				SPR_WAIT: if (get_ce && cpu_bus.rnw) state <= SPR_RUN;
				SPR_RUN: begin
					// A stolen GET neither advances nor latches
					if (get_ce && !dmc_busy) begin
						index   <= index + 9'd1;
						fetched <= 1'b1;
					end
					if (put_ce) begin
						fetched <= 1'b0;
						if (index[8])
							state <= SPR_IDLE;   // Byte $FF just written
						else if (dmc_busy)
							state <= SPR_WAIT;   // Realign after the DMC steal
					end
				end
				default: state <= SPR_IDLE;
			endcase
			if (trigger) begin
				state   <= SPR_WAIT;
				index   <= '0;
				fetched <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_ce && trigger)
			page <= cpu_bus.dout;
		if (get_ce && spr_run)
			spr_data <= bus_rdata;   // Held for the following write
	end

	// Own the bus on our own GETs and on PUTs that have a byte to write
	assign spr_run  = (state == SPR_RUN) && !dmc_busy && (!put_cycle || fetched);
	assign spr_wait = (state == SPR_WAIT) || ((state == SPR_RUN) && !spr_run);
	assign spr_addr = put_cycle ? ADDR_OAM_DATA : {page, index[7:0]};

endmodule

// File: src/dmc_dma.sv
// ##############################
// DMC sample DMA, steals a single
// GET cycle per request
// ##############################
module dmc_dma
	import nes_bus_pkg::*;
	import nes_timing_pkg::*;
(
	input  logic  clk,
	input  logic  reset,
	input  logic  get_ce,
	input  logic  put_ce,
	input  logic  put_cycle,
	input  logic  cpu_read,
	input  logic  dmc_req,
	input  data_t bus_rdata,
	output logic  dmc_busy,
	output logic  dmc_ack,
	output data_t dmc_data
);

	dmc_state_t state;
	data_t      sample;   // Byte fetched by the last ack

	always_ff @(posedge clk) begin
		if (reset)
			state <= DMC_IDLE;
		else if (state == DMC_IDLE && put_ce && dmc_req && cpu_read)
			state <= DMC_RUN;   // Only start on a CPU read cycle
		else if (state == DMC_RUN && put_ce)
			state <= DMC_IDLE;
	end

	always_ff @(posedge clk)
		if (get_ce && dmc_ack) sample <= bus_rdata;

	assign dmc_busy = (state == DMC_RUN);
	// Requester may drop its request before the GET comes round
	assign dmc_ack  = dmc_busy && !put_cycle && dmc_req;
	assign dmc_data = dmc_ack ? bus_rdata : sample;

endmodule

// File: src/joypad_port.sv
// ##############################
// Joypad port, strobe latch,
// clock pulses and read data
// ##############################
module joypad_port
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       put_ce,
	input  cpu_bus_t   cpu_bus,
	input  logic       dma_active,
	input  data_t      open_bus,
	input  pad_t       joypad1_data,
	input  pad_t       joypad2_data,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock,
	output logic       joy_sel,
	output data_t      joy_rdata
);

	logic [2:0] strobe;   // Last value written to $4016
	logic       joy1_rd;
	logic       joy2_rd;
	logic       joy_wr;

	// CPU accesses only, DMA cycles never reach the pads
	assign joy1_rd = cpu_bus.rnw && (cpu_bus.addr == ADDR_JOY1) && !dma_active;
	assign joy2_rd = cpu_bus.rnw && (cpu_bus.addr == ADDR_JOY2) && !dma_active;
	assign joy_wr  = !cpu_bus.rnw && (cpu_bus.addr == ADDR_JOY1) && !dma_active;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe     <= '0;
			joypad_out <= '0;
		end else begin
			if (joy_wr) strobe <= cpu_bus.dout[2:0];
			if (put_ce) joypad_out <= strobe;   // OUT pins follow on PUT
		end
	end

	assign joypad_clock = {joy2_rd, joy1_rd};
	assign joy_sel      = joy1_rd || joy2_rd;
	// Upper bits are undriven and show the open bus
	assign joy_rdata    = {open_bus[7:5], joy2_rd ? joypad2_data : joypad1_data};

endmodule

// File: src/bus_arbiter.sv
// ##############################
// Bus arbiter, memory request,
// CPU read data and open bus
// ##############################
module bus_arbiter
	import nes_bus_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     cpu_ce,
	input  logic     put_cycle,
	input  logic     spr_wait,
	input  logic     spr_run,
	input  logic     dmc_busy,
	input  logic     dmc_ack,
	input  logic     dmc_req,
	input  logic     joy_sel,
	input  cpu_bus_t cpu_bus,
	input  addr_t    spr_addr,
	input  data_t    spr_data,
	input  data_t    joy_rdata,
	input  data_t    mem_rdata,
	output mem_req_t mem_req,
	output data_t    bus_rdata,
	output data_t    cpu_din,
	output data_t    open_bus,
	output logic     pause_cpu
);

	logic  rd_int;    // Read before the APU window mask
	logic  wr_int;    // Write before the APU window mask
	logic  apu_win;
	data_t rd_data;

	assign pause_cpu = spr_wait || spr_run || dmc_req || dmc_busy;

	always_comb begin
		rd_int        = 1'b0;
		wr_int        = 1'b0;
		mem_req.addr  = cpu_bus.addr;
		mem_req.wdata = cpu_bus.dout;
		if (dmc_ack) begin
			mem_req.addr = spr_addr;   // Carries the DMC address here
			rd_int       = 1'b1;
		end else if (spr_run) begin
			mem_req.addr  = spr_addr;
			mem_req.wdata = spr_data;
			rd_int        = !put_cycle;
			wr_int        = put_cycle;
		end else if (!pause_cpu || !cpu_bus.rnw) begin
			// A halted CPU only holds reads, writes go through
			rd_int = cpu_bus.rnw;
			wr_int = !cpu_bus.rnw;
		end
		// APU registers live inside the 2A03 and never reach memory
		apu_win       = (mem_req.addr[15:5] == APU_PAGE);
		mem_req.read  = rd_int && !apu_win;
		mem_req.write = wr_int && !apu_win;
	end

	// Joypad first, then memory, else whatever the bus last held
	assign rd_data   = joy_sel ? joy_rdata : (mem_req.read ? mem_rdata : open_bus);
	assign cpu_din   = rd_data;
	assign bus_rdata = wr_int ? mem_req.wdata : rd_data;   // Byte on the bus

	always_ff @(posedge clk) begin
		if (reset)
			open_bus <= '0;
		else if (cpu_ce)
			open_bus <= bus_rdata;
	end

endmodule

// File: src/nes_bus_top.sv
// ##############################
// CPU side bus fabric of the NES
// ##############################
module nes_bus_top
	import nes_bus_pkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       dmc_req,
	input  cpu_bus_t   cpu_bus,
	input  addr_t      dmc_addr,
	input  data_t      mem_rdata,
	input  pad_t       joypad1_data,
	input  pad_t       joypad2_data,
	output mem_req_t   mem_req,
	output data_t      cpu_din,
	output data_t      dmc_data,
	output logic       cpu_ce,
	output logic       put_cycle,
	output logic       pause_cpu,
	output logic       dmc_ack,
	output logic [2:0] joypad_out,
	output logic [1:0] joypad_clock
);

	logic  get_ce;
	logic  put_ce;
	logic  spr_wait;
	logic  spr_run;
	logic  dmc_busy;
	logic  joy_sel;
	addr_t spr_addr;
	addr_t dma_addr;    // Address of whichever DMA owns the bus
	data_t spr_data;
	data_t bus_rdata;
	data_t open_bus;
	data_t joy_rdata;

	assign dma_addr = dmc_ack ? dmc_addr : spr_addr;   // DMC wins its GET

	nes_clock_gen clock_gen0 (.*);

	sprite_dma sprite_dma0 (.*);

	dmc_dma dmc_dma0 (.cpu_read(cpu_bus.rnw), .*);

	joypad_port joypad0 (.dma_active(pause_cpu), .*);

	bus_arbiter arbiter0 (.spr_addr(dma_addr), .*);

endmodule

// File: testbench/tb_clock.sv
// ##############################
// Testbench clock, period 40
// ##############################
module tb_clock (
	output logic clk
);

	initial clk = 1'b0;
	always #20 clk = !clk;   // 20 high, 20 low

endmodule

// File: testbench/nes_bus_checker.sv
// ##############################
// Bus fabric assertions, bound
// into the top level
// ##############################
module nes_bus_checker
	import nes_bus_pkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     cpu_ce,
	input logic     spr_run,
	input logic     pause_cpu,
	input logic     dmc_ack,
	input mem_req_t mem_req
);

	logic [3:0] gap;   // Clocks since the last cpu_ce

	always_ff @(posedge clk)
		gap <= (reset || cpu_ce) ? 4'd0 : gap + 4'd1;

	a_ce_period: assert property (@(posedge clk) disable iff (reset) cpu_ce == (gap == 4'd11))
		else $error("cpu_ce is not 12 clocks apart");
	a_ack_pause: assert property (@(posedge clk) disable iff (reset) dmc_ack |-> pause_cpu)
		else $error("dmc_ack without pause_cpu");
	a_rd_wr: assert property (@(posedge clk) disable iff (reset) !(mem_req.read && mem_req.write))
		else $error("Memory read and write at once");
	a_dma_dest: assert property (@(posedge clk) disable iff (reset)
		(spr_run && mem_req.write) |-> (mem_req.addr == ADDR_OAM_DATA))
		else $error("Sprite DMA write off the sprite port");

endmodule

// File: testbench/nes_bus_tb.sv
// ##############################
// Bus fabric testbench, random CPU
// traffic, DMA and joypad checks
// ##############################
module nes_bus_tb
	import nes_bus_pkg::*;
();

	localparam int N_CPU = 48;
	localparam int N_JOY = 12;
	localparam int N_APU = 12;
	localparam int DMA_CYC = 520;   // 514 plus trigger and stolen cycles
	localparam int LIMIT = (4 + N_CPU + 2 * DMA_CYC + 5 * N_JOY + 2 * N_APU) * 12 * 5 / 4;

	logic clk, reset, dmc_req, cpu_ce, put_cycle, pause_cpu, dmc_ack;
	cpu_bus_t cpu_bus;
	addr_t dmc_addr, addr_next, dmc_addr_next, a;
	data_t mem_rdata, cpu_din, dmc_data, last_byte, d;   // last_byte mirrors the open bus
	pad_t joypad1_data, joypad2_data, pad1_next, pad2_next;
	mem_req_t mem_req;
	logic [2:0] joypad_out;
	logic [1:0] joypad_clock;
	logic [15:0] lfsr = 16'd12;
	logic [15:0] r, n, wr_cnt, acks;
	logic rnw_next, dmc_next, exp_put, p;
	int checks = 0, errors = 0, cycles = 0;

	tb_clock clock0 (.clk(clk));
	nes_bus_top dut0 (.*);
	bind nes_bus_top nes_bus_checker checker0 (.clk(clk), .reset(reset), .cpu_ce(cpu_ce),
		.spr_run(spr_run), .pause_cpu(pause_cpu), .dmc_ack(dmc_ack), .mem_req(mem_req));

	assign mem_rdata = mem_model(mem_req.addr);

	function automatic data_t mem_model(input addr_t addr);
		return addr[15:8] ^ addr[7:0];   // Every byte depends on the whole address
	endfunction

	// Fibonacci LFSR x^16+x^14+x^13+x^11+1, one step per bit
	function automatic logic [15:0] rand_bits(input int bits);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < bits; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	task automatic check_addr(input string name, input addr_t exp, input addr_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic wait_ce();
		do @(negedge clk); while (!cpu_ce);   // Outputs settled mid cycle
	endtask

	// One bus cycle, inputs change on the edge that ends the last one
	task automatic bus_cycle(input addr_t addr, input logic rnw, input data_t dout);
		@(posedge clk);
		cpu_bus <= '{addr: addr, rnw: rnw, dout: dout};
		dmc_req <= dmc_next;
		dmc_addr <= dmc_addr_next;
		joypad1_data <= pad1_next;
		joypad2_data <= pad2_next;
		wait_ce();
		check_bit("put parity", exp_put, put_cycle);
		exp_put = !exp_put;
	endtask

	task automatic neutral_read();
		r = rand_bits(15);
		a = {1'b1, r[14:0]};   // Never the APU page
		bus_cycle(a, 1'b1, 8'h00);
		last_byte = mem_model(a);
	endtask

	task automatic sprite_dma_run(input data_t page, input logic with_dmc);
		bus_cycle(ADDR_OAM_DMA, 1'b0, page);
		r = rand_bits(6);
		n = 16'd0;
		wr_cnt = 16'd0;
		acks = 16'd0;
		do begin
			bus_cycle(16'h8000, 1'b1, 8'h00);   // CPU holds its read
			if (dmc_ack) begin
				acks = acks + 16'd1;
				check_addr("dmc addr", dmc_addr_next, mem_req.addr);
				check_data("dmc data", mem_model(dmc_addr_next), dmc_data);
				dmc_next = 1'b0;
			end
			if (mem_req.write) begin
				check_addr("spr dest", ADDR_OAM_DATA, mem_req.addr);
				check_data("spr data", mem_model({page, wr_cnt[7:0]}), mem_req.wdata);
				check_bit("spr pause", 1'b1, pause_cpu);
				wr_cnt = wr_cnt + 16'd1;
			end
			if (with_dmc && n == {10'd0, r[5:0]} + 16'd8) dmc_next = 1'b1;
			n = n + 16'd1;
		end while (pause_cpu && n < 16'd600);
		if (n >= 16'd600) begin
			errors++;
			$display("Sprite DMA did not finish within 600 bus cycles");
		end
		check_addr("spr write count", 16'd256, wr_cnt);
		check_addr("dmc ack count", {15'd0, with_dmc}, acks);
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout, the tests did not end within %0d clocks", LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		cpu_bus = '{addr: 16'h0000, rnw: 1'b1, dout: 8'h00};
		dmc_req = 1'b0;
		dmc_next = 1'b0;
		dmc_addr = 16'h0000;
		dmc_addr_next = 16'h0000;
		joypad1_data = '0;
		joypad2_data = '0;
		pad1_next = '0;
		pad2_next = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		wait_ce();
		check_bit("reset put", 1'b1, put_cycle);   // First cycle after reset is odd
		check_bit("reset pause", 1'b0, pause_cpu);
		check_bit("reset ack", 1'b0, dmc_ack);
		check_bit("reset joy clock", 1'b0, |joypad_clock);
		check_bit("reset mem write", 1'b0, mem_req.write);
		check_data("reset joy out", 8'h00, {5'd0, joypad_out});
		exp_put = 1'b0;
		for (int i = 0; i < N_CPU; i++) begin
			r = rand_bits(16);
			addr_next = (r[15:5] == APU_PAGE) ? r ^ 16'h8000 : r;
			r = rand_bits(9);
			rnw_next = r[8];
			bus_cycle(addr_next, rnw_next, r[7:0]);
			check_addr("cpu addr", addr_next, mem_req.addr);
			check_bit("cpu read", rnw_next, mem_req.read);
			check_bit("cpu write", !rnw_next, mem_req.write);
			check_bit("cpu pause", 1'b0, pause_cpu);
			if (rnw_next) check_data("cpu din", mem_model(addr_next), cpu_din);
			else check_data("cpu wdata", r[7:0], mem_req.wdata);
		end
		r = rand_bits(8);
		if (r[7:0] == APU_PAGE[10:3]) r[7] = 1'b1;   // Source page outside the APU registers
		sprite_dma_run(r[7:0], 1'b0);
		r = rand_bits(15);
		dmc_addr_next = {1'b1, r[14:0]};
		r = rand_bits(8);
		if (r[7:0] == APU_PAGE[10:3]) r[7] = 1'b1;
		sprite_dma_run(r[7:0], 1'b1);
		for (int i = 0; i < N_JOY; i++) begin
			r = rand_bits(3);
			d = {5'd0, r[2:0]};
			bus_cycle(ADDR_JOY1, 1'b0, d);
			p = put_cycle;
			check_bit("strobe mem write", 1'b0, mem_req.write);
			neutral_read();
			if (!p) neutral_read();   // Output follows on the next PUT
			check_data("joypad out", d, {5'd0, joypad_out});
			for (int port = 0; port < 2; port++) begin
				r = rand_bits(10);
				pad1_next = r[4:0];
				pad2_next = r[9:5];
				bus_cycle(port == 0 ? ADDR_JOY1 : ADDR_JOY2, 1'b1, 8'h00);
				d = {last_byte[7:5], port == 0 ? pad1_next : pad2_next};
				check_data("joypad read", d, cpu_din);
				check_bit("joy clock 1", port == 0, joypad_clock[0]);
				check_bit("joy clock 2", port == 1, joypad_clock[1]);
				last_byte = d;
			end
		end
		for (int i = 0; i < N_APU; i++) begin
			neutral_read();
			r = rand_bits(5);
			a = {APU_PAGE, r[4:0]};
			if (a == ADDR_JOY1 || a == ADDR_JOY2) a = 16'h4015;
			bus_cycle(a, 1'b1, 8'h00);
			check_bit("apu no read", 1'b0, mem_req.read);
			check_data("apu open bus", last_byte, cpu_din);
		end
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: list.f
src/nes_bus_pkg.sv
src/nes_timing_pkg.sv
src/nes_clock_gen.sv
src/sprite_dma.sv
src/dmc_dma.sv
src/joypad_port.sv
src/bus_arbiter.sv
src/nes_bus_top.sv
testbench/tb_clock.sv
testbench/nes_bus_checker.sv
testbench/nes_bus_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the bus fabric testbench with Verilator

verilator --binary --timing --assert -f list.f --top-module nes_bus_tb -o nes_bus_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/nes_bus_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
